// ==== logic/dbg_defs.svh ====
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

////////////////////
// Dump layout
////////////////////

// Register-file words sent by the collector
`define DBG_NUM_REGS 32

// Data-memory words sent after the registers
`define DBG_NUM_MEM 16

// pc, four latches and cycle count, 4 bytes each
`define DBG_SNAP_BYTES 24

// Instruction memory
`define DBG_IMEM_AW 6

`endif

// ==== logic/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    ////////////////////
    // Host commands
    ////////////////////

    typedef enum logic [7:0] {
        CMD_START      = 8'd1,
        CMD_CONTINUOUS = 8'd2,
        CMD_STEP_MODE  = 8'd3,
        CMD_REPROGRAM  = 8'd5,
        CMD_STEP       = 8'd6
    } cmd_t;

    ////////////////////
    // Program words
    ////////////////////

    // Same received word, seen as UART bytes or as instruction fields
    typedef union packed {
        logic [3:0][7:0] bytes;       // Byte 0 arrives first
        struct packed {
            logic [5:0]  opcode;      // All ones marks the halt word
            logic [25:0] rest;
        } fields;
    } instr_word_t;

endpackage

`default_nettype wire

// ==== logic/dbg_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dbg_ctrl_if;

    logic          loading;       // Programming mode level
    logic          cmd_valid;
    dbg_pkg::cmd_t cmd;
    logic          prog_done;     // Halt word written
    logic          dump_start;
    logic [31:0]   run_cycles;
    logic          dump_done;

    modport decode (
        input  loading,
        output cmd_valid,
        output cmd,
        output prog_done
    );

    modport execute (
        output loading,
        input  cmd_valid,
        input  cmd,
        input  prog_done,
        output dump_start,
        output run_cycles,
        input  dump_done
    );

    modport result (
        input  dump_start,
        input  run_cycles,
        output dump_done
    );

endinterface

`default_nettype wire

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module cmd_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_done,
    input  logic [7:0]              rx_data,
    output logic                    imem_we,
    output logic [`DBG_IMEM_AW-1:0] imem_addr,
    output logic [31:0]             imem_data,
    dbg_ctrl_if.decode              ctl
);

    dbg_pkg::instr_word_t    word_q;
    dbg_pkg::instr_word_t    word_d;
    logic [1:0]              byte_pos;
    logic [`DBG_IMEM_AW-1:0] wr_addr;
    logic                    prog_byte;
    logic                    word_end;
    logic                    halt_word;
    logic                    is_cmd;

    assign prog_byte = rx_done && ctl.loading;
    assign word_end  = prog_byte && (byte_pos == 2'd3);
    assign halt_word = &word_d.fields.opcode;

    // Word with the incoming byte merged in
    always_comb begin
        word_d = word_q;
        word_d.bytes[byte_pos] = rx_data;
    end

    always_comb begin
        case (rx_data)
            dbg_pkg::CMD_START,
            dbg_pkg::CMD_CONTINUOUS,
            dbg_pkg::CMD_STEP_MODE,
            dbg_pkg::CMD_REPROGRAM,
            dbg_pkg::CMD_STEP: is_cmd = 1'b1;
            default:           is_cmd = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            byte_pos      <= 2'd0;
            wr_addr       <= '0;
            imem_we       <= 1'b0;
            imem_addr     <= '0;
            ctl.prog_done <= 1'b0;
            ctl.cmd_valid <= 1'b0;
        end else begin
            imem_we       <= word_end;
            ctl.prog_done <= word_end && halt_word;
            ctl.cmd_valid <= rx_done && !ctl.loading && is_cmd;
            if (prog_byte) begin
                byte_pos <= byte_pos + 2'd1;   // Wraps to 0 after byte 3
            end
            if (word_end) begin
                imem_addr <= wr_addr;
                if (halt_word) begin
                    wr_addr <= '0;             // Next load starts over
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prog_byte) begin
            word_q <= word_d;
        end
        if (word_end) begin
            imem_data <= word_d;
        end
        if (rx_done && !ctl.loading) begin
            ctl.cmd <= dbg_pkg::cmd_t'(rx_data);
        end
    end

endmodule

`default_nettype wire

// ==== logic/run_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module run_controller (
    input  logic        clk,
    input  logic        reset,
    input  logic        halt,
    output logic        cpu_reset,
    output logic        cpu_run,
    dbg_ctrl_if.execute ctl
);

    localparam logic [2:0] MODE_IDLE        = 3'd0;
    localparam logic [2:0] MODE_PROGRAMMING = 3'd1;
    localparam logic [2:0] MODE_WAITING     = 3'd2;
    localparam logic [2:0] MODE_STEPPING    = 3'd3;
    localparam logic [2:0] MODE_RUNNING     = 3'd4;
    localparam logic [2:0] MODE_DUMPING     = 3'd5;

    logic [2:0] mode;

    assign ctl.loading = (mode == MODE_PROGRAMMING);
    assign cpu_reset   = (mode == MODE_PROGRAMMING) || (mode == MODE_WAITING);

    ////////////////////
    // Mode machine
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mode           <= MODE_PROGRAMMING;
            cpu_run        <= 1'b0;
            ctl.dump_start <= 1'b0;
            ctl.run_cycles <= '0;
        end else begin
            ctl.dump_start <= 1'b0;

            if (mode == MODE_WAITING) begin
                ctl.run_cycles <= '0;
            end else if (cpu_run) begin
                ctl.run_cycles <= ctl.run_cycles + 32'd1;
            end

            case (mode)
                MODE_IDLE: begin
                    if (ctl.cmd_valid && ctl.cmd == dbg_pkg::CMD_START) begin
                        mode <= MODE_PROGRAMMING;
                    end
                end
                MODE_PROGRAMMING: begin
                    if (ctl.prog_done) begin
                        mode <= MODE_WAITING;
                    end
                end
                MODE_WAITING: begin
                    if (ctl.cmd_valid) begin
                        case (ctl.cmd)
                            dbg_pkg::CMD_REPROGRAM: mode <= MODE_IDLE;
                            dbg_pkg::CMD_CONTINUOUS: begin
                                mode    <= MODE_RUNNING;
                                cpu_run <= 1'b1;
                            end
                            dbg_pkg::CMD_STEP_MODE: mode <= MODE_STEPPING;
                            default: ;
                        endcase
                    end
                end
                MODE_STEPPING: begin
                    if (cpu_run) begin
                        // Single enabled cycle is over
                        cpu_run        <= 1'b0;
                        ctl.dump_start <= 1'b1;
                        mode           <= MODE_DUMPING;
                    end else if (ctl.cmd_valid && ctl.cmd == dbg_pkg::CMD_STEP) begin
                        cpu_run <= 1'b1;
                    end
                end
                MODE_RUNNING: begin
                    if (halt) begin
                        cpu_run        <= 1'b0;
                        ctl.dump_start <= 1'b1;
                        mode           <= MODE_DUMPING;
                    end
                end
                MODE_DUMPING: begin
                    if (ctl.dump_done) begin
                        mode <= halt ? MODE_WAITING : MODE_STEPPING;
                    end
                end
                default: mode <= MODE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/dump_sender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module dump_sender (
    input  logic        clk,
    input  logic        reset,
    input  logic        tx_done,
    input  logic [31:0] pc,
    input  logic [31:0] latch_if_id,
    input  logic [31:0] latch_id_ex,
    input  logic [31:0] latch_ex_mem,
    input  logic [31:0] latch_mem_wb,
    input  logic [31:0] collector_word,
    output logic        tx_start,
    output logic [7:0]  tx_data,
    output logic        collector_sel_regs,
    output logic        collector_next,
    output logic        collector_restart,
    dbg_ctrl_if.result  ctl
);

    localparam int SNAP_IW = $clog2(`DBG_SNAP_BYTES);
    localparam int WORDS   = `DBG_NUM_REGS + `DBG_NUM_MEM;
    localparam int WORD_W  = $clog2(WORDS);

    logic [`DBG_SNAP_BYTES/4-1:0][3:0][7:0] snap;   // Word 0 is pc
    logic [3:0][7:0]    cw;
    logic               busy;
    logic               in_snap;
    logic               fetch;                      // New collector word visible
    logic [SNAP_IW-1:0] snap_idx;
    logic [SNAP_IW-1:0] snap_nxt;
    logic [WORD_W-1:0]  word_cnt;
    logic [1:0]         byte_cnt;
    logic [1:0]         byte_nxt;
    logic               load_byte;
    logic [7:0]         next_data;

    assign cw       = collector_word;
    assign snap_nxt = snap_idx + SNAP_IW'(1);
    assign byte_nxt = byte_cnt + 2'd1;
    assign collector_sel_regs = busy && (word_cnt < WORD_W'(`DBG_NUM_REGS));

    ////////////////////
    // Next byte to send
    ////////////////////

    always_comb begin
        load_byte = 1'b0;
        next_data = cw[0];
        if (!busy) begin
            load_byte = ctl.dump_start;
            next_data = pc[7:0];
        end else if (fetch) begin
            load_byte = 1'b1;
        end else if (tx_done) begin
            if (in_snap) begin
                load_byte = 1'b1;
                if (snap_idx != SNAP_IW'(`DBG_SNAP_BYTES - 1)) begin
                    next_data = snap[snap_nxt[SNAP_IW-1:2]][snap_nxt[1:0]];
                end
            end else if (byte_cnt != 2'd3) begin
                load_byte = 1'b1;
                next_data = cw[byte_nxt];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy              <= 1'b0;
            in_snap           <= 1'b0;
            fetch             <= 1'b0;
            snap_idx          <= '0;
            word_cnt          <= '0;
            byte_cnt          <= 2'd0;
            tx_start          <= 1'b0;
            collector_next    <= 1'b0;
            collector_restart <= 1'b0;
            ctl.dump_done     <= 1'b0;
        end else begin
            tx_start          <= load_byte;
            collector_next    <= 1'b0;
            collector_restart <= 1'b0;
            ctl.dump_done     <= 1'b0;
            fetch             <= collector_next && busy;
            if (!busy) begin
                if (ctl.dump_start) begin
                    busy     <= 1'b1;
                    in_snap  <= 1'b1;
                    snap_idx <= '0;
                    word_cnt <= '0;
                    byte_cnt <= 2'd0;
                end
            end else if (tx_done) begin
                if (in_snap) begin
                    if (snap_idx == SNAP_IW'(`DBG_SNAP_BYTES - 1)) begin
                        in_snap <= 1'b0;
                    end else begin
                        snap_idx <= snap_nxt;
                    end
                end else if (byte_cnt == 2'd3) begin
                    collector_next <= 1'b1;
                    byte_cnt       <= 2'd0;
                    if (word_cnt == WORD_W'(WORDS - 1)) begin
                        busy              <= 1'b0;
                        collector_restart <= 1'b1;
                        ctl.dump_done     <= 1'b1;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end else begin
                    byte_cnt <= byte_nxt;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && ctl.dump_start) begin
            snap <= {ctl.run_cycles, latch_mem_wb, latch_ex_mem, latch_id_ex, latch_if_id, pc};
        end
        if (load_byte) begin
            tx_data <= next_data;   // Held until the next load
        end
    end

endmodule

`default_nettype wire

// ==== logic/debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module debug_unit (
    input  logic                    clk,
    input  logic                    reset,
    // UART
    input  logic                    rx_done,
    input  logic [7:0]              rx_data,
    input  logic                    tx_done,
    output logic                    tx_start,
    output logic [7:0]              tx_data,
    // Instruction memory
    output logic                    imem_we,
    output logic [`DBG_IMEM_AW-1:0] imem_addr,
    output logic [31:0]             imem_data,
    // Processor
    output logic                    cpu_reset,
    output logic                    cpu_run,
    input  logic                    halt,
    input  logic [31:0]             pc,
    input  logic [31:0]             latch_if_id,
    input  logic [31:0]             latch_id_ex,
    input  logic [31:0]             latch_ex_mem,
    input  logic [31:0]             latch_mem_wb,
    // Collector
    input  logic [31:0]             collector_word,
    output logic                    collector_sel_regs,
    output logic                    collector_next,
    output logic                    collector_restart
);

    dbg_ctrl_if ctl ();

    cmd_decoder decode_i (
        .clk       (clk),
        .reset     (reset),
        .rx_done   (rx_done),
        .rx_data   (rx_data),
        .imem_we   (imem_we),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ctl       (ctl.decode)
    );

    run_controller execute_i (
        .clk       (clk),
        .reset     (reset),
        .halt      (halt),
        .cpu_reset (cpu_reset),
        .cpu_run   (cpu_run),
        .ctl       (ctl.execute)
    );

    dump_sender result_i (
        .clk                (clk),
        .reset              (reset),
        .tx_done            (tx_done),
        .pc                 (pc),
        .latch_if_id        (latch_if_id),
        .latch_id_ex        (latch_id_ex),
        .latch_ex_mem       (latch_ex_mem),
        .latch_mem_wb       (latch_mem_wb),
        .collector_word     (collector_word),
        .tx_start           (tx_start),
        .tx_data            (tx_data),
        .collector_sel_regs (collector_sel_regs),
        .collector_next     (collector_next),
        .collector_restart  (collector_restart),
        .ctl                (ctl.result)
    );

endmodule

`default_nettype wire

// ==== tests/debug_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module debug_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rx_done,
    input  logic [7:0]              rx_data,
    input  logic                    tx_done,
    input  logic                    tx_start,
    input  logic [7:0]              tx_data,
    input  logic                    imem_we,
    input  logic [`DBG_IMEM_AW-1:0] imem_addr,
    input  logic [31:0]             imem_data,
    input  logic                    cpu_reset,
    input  logic                    cpu_run,
    input  logic                    halt,
    input  logic [31:0]             pc,
    input  logic [31:0]             latch_if_id,
    input  logic [31:0]             latch_id_ex,
    input  logic [31:0]             latch_ex_mem,
    input  logic [31:0]             latch_mem_wb,
    input  logic                    collector_sel_regs,
    input  logic                    collector_next,
    input  logic                    collector_restart,
    output int                      errors,
    output int                      dumps
);

    localparam int M_IDLE = 0;
    localparam int M_PROG = 1;
    localparam int M_WAIT = 2;
    localparam int M_RUN  = 3;
    localparam int M_STEP = 4;
    localparam int DUMP_BYTES = `DBG_SNAP_BYTES + 4 * (`DBG_NUM_REGS + `DBG_NUM_MEM);

    int          mode;
    logic [31:0] word;
    int          byte_pos;
    int          wr_addr;
    logic        exp_we;
    int          exp_addr;
    logic [31:0] exp_data;
    logic        prev_run;
    logic        prev_halt;
    logic [31:0] cycles;
    int          runs_in_dump;
    logic        outstanding;
    int          byte_cnt;
    int          next_cnt;
    logic        check_reset;
    logic [7:0]  exp_q[$];

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("%0t error: %s", $time, msg);
        errors++;
    endtask

    // Collector contents as the dump should carry them
    function automatic logic [31:0] expected_word(input int w);
        if (w < `DBG_NUM_REGS) begin
            return 32'h5200_0000 + w * 32'h0001_0307;
        end
        return 32'h6D00_0000 ^ (w * 32'h0102_0409);
    endfunction

    task automatic push_word(input logic [31:0] v);
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(v[8*k +: 8]);   // LSB first
        end
    endtask

    ////////////////////
    // Program load
    ////////////////////

    always @(negedge clk) begin
        if (reset) begin
            mode     = M_PROG;
            byte_pos = 0;
            wr_addr  = 0;
            exp_we   = 1'b0;
        end else begin
            if (imem_we !== exp_we) begin
                report_mismatch("imem_we", exp_we, imem_we);
            end else if (exp_we) begin
                if (imem_addr !== exp_addr[`DBG_IMEM_AW-1:0]) begin
                    report_mismatch("imem_addr", exp_addr, imem_addr);
                end
                if (imem_data !== exp_data) begin
                    report_mismatch("imem_data", exp_data, imem_data);
                end
            end
            exp_we = 1'b0;
            if (rx_done) begin
                case (mode)
                    M_PROG: begin
                        if (cpu_reset !== 1'b1) begin
                            report_error("cpu_reset low while loading");
                        end
                        word[8*byte_pos +: 8] = rx_data;
                        byte_pos++;
                        if (byte_pos == 4) begin
                            exp_we   = 1'b1;
                            exp_addr = wr_addr;
                            exp_data = word;
                            byte_pos = 0;
                            wr_addr++;
                            if (&word[31:26]) begin   // Halt opcode ends the load
                                mode    = M_WAIT;
                                wr_addr = 0;
                            end
                        end
                    end
                    M_WAIT: begin
                        if (rx_data == 8'd5) mode = M_IDLE;
                        if (rx_data == 8'd2) mode = M_RUN;
                        if (rx_data == 8'd3) mode = M_STEP;
                    end
                    M_IDLE: begin
                        if (rx_data == 8'd1) mode = M_PROG;
                    end
                    default: ;
                endcase
            end
        end
    end

    ////////////////////
    // Run control and dump
    ////////////////////

    always @(negedge clk) begin
        if (reset) begin
            errors       = 0;
            dumps        = 0;
            prev_run     = 1'b0;
            prev_halt    = 1'b0;
            cycles       = '0;
            runs_in_dump = 0;
            outstanding  = 1'b0;
            byte_cnt     = 0;
            next_cnt     = 0;
            check_reset  = 1'b0;
            exp_q.delete();
        end else begin
            if (check_reset && cpu_reset !== 1'b1) begin
                report_error("cpu_reset not high again after a halted dump");
            end
            check_reset = 1'b0;
            if (cpu_run && cpu_reset) begin
                report_error("cpu_run and cpu_reset high together");
            end
            if (mode == M_STEP && prev_run && cpu_run) begin
                report_error("step gave more than one cpu_run cycle");
            end
            if (mode == M_RUN && prev_run && !prev_halt && !cpu_run) begin
                report_error("cpu_run dropped before halt");
            end
            if (mode == M_RUN && prev_run && prev_halt && cpu_run) begin
                report_error("cpu_run stayed high after halt");
            end

            // Count starts over each time the unit waits for a command
            if (mode == M_WAIT) begin
                cycles = '0;
            end else if (cpu_run) begin
                cycles++;
                runs_in_dump++;
            end

            // Snapshot taken where cpu_run falls
            if (prev_run && !cpu_run) begin
                if (mode == M_STEP && runs_in_dump != 1) begin
                    report_mismatch("step cpu_run cycles", 1, runs_in_dump);
                end
                runs_in_dump = 0;
                push_word(pc);
                push_word(latch_if_id);
                push_word(latch_id_ex);
                push_word(latch_ex_mem);
                push_word(latch_mem_wb);
                push_word(cycles);
                for (int w = 0; w < `DBG_NUM_REGS + `DBG_NUM_MEM; w++) begin
                    push_word(expected_word(w));
                end
            end

            if (tx_start) begin
                if (outstanding) begin
                    report_error("tx_start before the preceding tx_done");
                end
                outstanding = 1'b1;
                byte_cnt++;
                if (exp_q.size() == 0) begin
                    report_error("tx byte with no dump expected");
                end else if (tx_data !== exp_q[0]) begin
                    report_mismatch("tx_data", exp_q[0], tx_data);
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
                if (byte_cnt > `DBG_SNAP_BYTES) begin
                    if (collector_sel_regs !==
                        ((byte_cnt - `DBG_SNAP_BYTES - 1) / 4 < `DBG_NUM_REGS)) begin
                        report_mismatch("collector_sel_regs",
                                        (byte_cnt - `DBG_SNAP_BYTES - 1) / 4 < `DBG_NUM_REGS,
                                        collector_sel_regs);
                    end
                end
            end
            if (tx_done) begin
                outstanding = 1'b0;
            end
            if (collector_next) begin
                next_cnt++;
            end

            if (collector_restart) begin
                if (byte_cnt != DUMP_BYTES) begin
                    report_mismatch("dump byte count", DUMP_BYTES, byte_cnt);
                end
                if (next_cnt != `DBG_NUM_REGS + `DBG_NUM_MEM) begin
                    report_mismatch("collector_next count", `DBG_NUM_REGS + `DBG_NUM_MEM,
                                    next_cnt);
                end
                if (exp_q.size() != 0) begin
                    report_error("dump ended with bytes still expected");
                    exp_q.delete();
                end
                if (halt) begin
                    mode        = M_WAIT;
                    check_reset = 1'b1;
                end
                byte_cnt = 0;
                next_cnt = 0;
                dumps++;
            end
            prev_run  = cpu_run;
            prev_halt = halt;
        end
    end

endmodule

`default_nettype wire

// ==== tests/debug_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_defs.svh"

module debug_unit_tb;

    logic                    clk;
    logic                    reset;
    logic                    rx_done;
    logic [7:0]              rx_data;
    logic                    tx_done;
    logic                    tx_start;
    logic [7:0]              tx_data;
    logic                    imem_we;
    logic [`DBG_IMEM_AW-1:0] imem_addr;
    logic [31:0]             imem_data;
    logic                    cpu_reset;
    logic                    cpu_run;
    logic                    halt;
    logic [31:0]             pc;
    logic [31:0]             latch_if_id;
    logic [31:0]             latch_id_ex;
    logic [31:0]             latch_ex_mem;
    logic [31:0]             latch_mem_wb;
    logic [31:0]             collector_word;
    logic                    collector_sel_regs;
    logic                    collector_next;
    logic                    collector_restart;
    int                      errors;
    int                      dumps;

    logic [31:0] rng;
    logic [31:0] cpu_count;
    logic [31:0] halt_target;
    int          coll_pos;
    int          limit;
    int          cycle_cnt;
    logic        run_s;
    logic        rst_s;
    logic        next_s;
    logic        restart_s;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Worst-case cycles for the work about to be queued
    task automatic add_budget(input int runs, input int bytes);
        limit += runs * (216 * 10 + 200) + bytes * 20;
    endtask

    // At least one idle cycle between bytes, as on a real UART
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 1 + next_rand() % 4;
        repeat (gap) tick();
        rx_data = b;
        rx_done = 1'b1;
        tick();
        rx_done = 1'b0;
    endtask

    task automatic send_junk();
        logic [7:0] b;
        b = 8'(next_rand());
        b[7] = 1'b1;               // Never a command value
        send_byte(b);
    endtask

    task automatic load_program();
        dbg_pkg::instr_word_t w;
        int n;
        n = 2 + next_rand() % 6;
        halt_target = 1 + next_rand() % 6;
        add_budget(0, 4 * (n + 1) + 2);
        for (int i = 0; i <= n; i++) begin
            w = next_rand();
            if (i == n) begin
                w.fields.opcode = 6'h3F;
            end else if (&w.fields.opcode) begin
                w.fields.opcode[5] = 1'b0;
            end
            for (int k = 0; k < 4; k++) begin
                send_byte(w.bytes[k]);
            end
        end
        send_junk();
        send_junk();
    endtask

    task automatic wait_dump(output logic halted);
        do begin
            @(negedge clk);
        end while (!collector_restart);
        halted = halt;
        tick();
    endtask

    task automatic run_session();
        logic halted;
        if (next_rand() % 2) begin
            add_budget(1, 1);
            send_byte(dbg_pkg::CMD_CONTINUOUS);
            wait_dump(halted);
        end else begin
            add_budget(0, 1);
            send_byte(dbg_pkg::CMD_STEP_MODE);
            do begin
                add_budget(1, 1);
                send_byte(dbg_pkg::CMD_STEP);
                wait_dump(halted);
            end while (!halted);
        end
    endtask

    ////////////////////
    // Stubs
    ////////////////////

    assign halt         = (cpu_count >= halt_target);
    assign pc           = cpu_count * 4;
    assign latch_if_id  = (cpu_count * 32'h0100_0001) ^ 32'h1111_0000;
    assign latch_id_ex  = ~cpu_count;
    assign latch_ex_mem = {cpu_count[23:0], 8'hE1};
    assign latch_mem_wb = {cpu_count[15:0], ~cpu_count[15:0]};
    assign collector_word = collector_sel_regs ? 32'h5200_0000 + coll_pos * 32'h0001_0307
                                               : 32'h6D00_0000 ^ (coll_pos * 32'h0102_0409);

    always @(posedge clk) begin
        run_s     = cpu_run;
        rst_s     = cpu_reset;
        next_s    = collector_next;
        restart_s = collector_restart;
        #1;
        if (rst_s) begin
            cpu_count = '0;
        end else if (run_s) begin
            cpu_count = cpu_count + 1;
        end
        if (restart_s) begin
            coll_pos = 0;
        end else if (next_s) begin
            coll_pos = coll_pos + 1;
        end
    end

    // UART transmitter with random completion delay
    initial begin
        int d;
        forever begin
            @(negedge clk);
            if (tx_start) begin
                d = 1 + next_rand() % 8;
                repeat (d) @(posedge clk);
                #1 tx_done = 1'b1;
                @(posedge clk);
                #1 tx_done = 1'b0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > limit) begin
            $display("Timeout: no finish after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    debug_unit debug_unit_i (.*);

    debug_checker debug_checker_i (.*);

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        rng         = 32'd88;
        reset       = 1'b1;
        rx_done     = 1'b0;
        rx_data     = 8'h00;
        tx_done     = 1'b0;
        cpu_count   = '0;
        halt_target = 32'd1;
        coll_pos    = 0;
        cycle_cnt   = 0;
        limit       = 100;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;

        load_program();                        // Unit leaves reset in programming mode
        for (int l = 0; l < 3; l++) begin
            run_session();
            run_session();
            if (l < 2) begin
                add_budget(0, 4);
                send_byte(dbg_pkg::CMD_REPROGRAM);
                send_junk();
                send_junk();
                send_byte(dbg_pkg::CMD_START);
                load_program();
            end
        end
        repeat (10) tick();

        $display("Errors: %0d over %0d dumps", errors, dumps);
        if (errors == 0 && dumps > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/dbg_pkg.sv
logic/dbg_ctrl_if.sv
logic/cmd_decoder.sv
logic/run_controller.sv
logic/dump_sender.sv
logic/debug_unit.sv
tests/debug_checker.sv
tests/debug_unit_tb.sv
